// File: dma_cfg.svh
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// dram side
`define DMA_ADDR_W      32
`define DMA_WORD_W      32
`define DMA_DRAM_A_W    12
`define DMA_ROW_LSB     12
`define DMA_ROW_MSB     23
`define DMA_COL_LSB     2
`define DMA_COL_MSB     11
`define DMA_WORD_BYTES  4

// line shapes, weight line is one 3x3 kernel
`define DMA_IN_WORDS    4
`define DMA_WT_WORDS    9
`define DMA_MAX_WORDS   `DMA_WT_WORDS
`define DMA_IN_LINE_W   128
`define DMA_WT_LINE_W   288

`define DMA_BUF_A_W     7

// column command to read data
`define DMA_CAS_LAT     2

`endif

// File: dma_pkg.sv
package dma_pkg;

	// per-line sequence of the read engine
	typedef enum logic [2:0]
	{
		ST_IDLE  = 3'd0,
		// open the row of the line
		ST_ROW   = 3'd1,
		// one column command per word
		ST_COL   = 3'd2,
		// wait for words still in flight
		ST_DRAIN = 3'd3,
		// hand the full line to the buffer writer
		ST_WRITE = 3'd4
	} dma_state_t;

	// which ping-pong buffer pair a job fills
	typedef enum logic
	{
		BUF_INPUT  = 1'b0,
		BUF_WEIGHT = 1'b1
	} buf_kind_t;

endpackage

// File: dram_burst_ctrl.sv
`timescale 1ns/100ps
`include "dma_cfg.svh"

module dram_burst_ctrl
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  dma_pkg::buf_kind_t       target,
	input  logic [`DMA_ADDR_W-1:0]   dram_addr_start,
	input  logic [`DMA_ADDR_W-1:0]   dram_addr_end,
	input  logic                     word_taken,
	output logic                     dram_ras_n,
	output logic                     dram_cas_n,
	output logic [`DMA_DRAM_A_W-1:0] dram_a,
	output logic                     col_issue,
	output logic                     job_start,
	output logic                     line_write,
	output logic                     last_line,
	output logic                     done,
	output logic                     busy
);
	import dma_pkg::*;

	localparam int CNT_W = $clog2(`DMA_MAX_WORDS + 1);
	localparam int COL_W = `DMA_COL_MSB - `DMA_COL_LSB + 1;
	localparam logic [`DMA_ADDR_W-1:0] STEP = `DMA_WORD_BYTES;

	dma_state_t state;
	dma_state_t next_state;
	logic accept;
	logic [CNT_W-1:0] line_words;
	logic [CNT_W-1:0] col_cnt;
	logic [CNT_W-1:0] taken_cnt;
	logic [`DMA_ADDR_W-1:0] addr_q;
	logic last_q;

	// done cycle still counts as busy, so a start there is dropped
	assign accept = (state == ST_IDLE) && start && !done;
	assign line_words = (target == BUF_WEIGHT) ? CNT_W'(`DMA_WT_WORDS) : CNT_W'(`DMA_IN_WORDS);

	always_comb
	begin
		next_state = state;
		case (state)
			ST_IDLE:
				if (accept)
					next_state = ST_ROW;
			ST_ROW:
				next_state = ST_COL;
			ST_COL:
				if (col_cnt == line_words - 1'b1)
					next_state = ST_DRAIN;
			ST_DRAIN:
				if (word_taken && taken_cnt == line_words - 1'b1)
					next_state = ST_WRITE;
			ST_WRITE:
				next_state = last_q ? ST_IDLE : ST_ROW;
			default:
				next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	// word counters, cleared while the row opens
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			col_cnt <= '0;
			taken_cnt <= '0;
		end
		else
		begin
			if (state == ST_ROW)
				col_cnt <= '0;
			else if (state == ST_COL)
				col_cnt <= col_cnt + 1'b1;

			if (state == ST_ROW)
				taken_cnt <= '0;
			else if (word_taken)
				taken_cnt <= taken_cnt + 1'b1;
		end
	end

	// byte address of the next column command
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			addr_q <= '0;
			last_q <= 1'b0;
		end
		else if (accept)
		begin
			addr_q <= dram_addr_start;
			last_q <= 1'b0;
		end
		else if (state == ST_COL)
		begin
			addr_q <= addr_q + STEP;
			if (addr_q == dram_addr_end)
				last_q <= 1'b1;
		end
	end

	// pins follow the state one stage later
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			dram_ras_n <= 1'b1;
			dram_cas_n <= 1'b1;
			dram_a <= '0;
		end
		else
		begin
			dram_ras_n <= !(state == ST_ROW || state == ST_COL);
			dram_cas_n <= !(state == ST_COL);
			if (state == ST_ROW)
				dram_a <= addr_q[`DMA_ROW_MSB:`DMA_ROW_LSB];
			else if (state == ST_COL)
				dram_a <= {{(`DMA_DRAM_A_W - COL_W){1'b0}}, addr_q[`DMA_COL_MSB:`DMA_COL_LSB]};
		end
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			job_start <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			job_start <= accept;
			// lands with the writer's registered enables
			done <= (state == ST_WRITE) && last_q;
		end
	end

	assign col_issue = !dram_cas_n;
	assign line_write = (state == ST_WRITE);
	assign last_line = (state == ST_WRITE) && last_q;
	assign busy = (state != ST_IDLE) || done;

endmodule

// File: word_gather.sv
`timescale 1ns/100ps
`include "dma_cfg.svh"

module word_gather
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      col_issue,
	input  logic [`DMA_WORD_W-1:0]    dram_q,
	output logic                      word_taken,
	output logic [`DMA_WT_LINE_W-1:0] line
);

	localparam int SLOT_W = $clog2(`DMA_MAX_WORDS);

	logic [`DMA_CAS_LAT-1:0] issue_dly;
	logic [SLOT_W-1:0] slot;

	// one stage per cycle of cas latency
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			issue_dly <= '0;
		else
		begin
			issue_dly[0] <= col_issue;
			for (int i = 1; i < `DMA_CAS_LAT; i++)
			begin
				issue_dly[i] <= issue_dly[i-1];
			end
		end
	end

	assign word_taken = issue_dly[`DMA_CAS_LAT-1];

	// restarts in the gap between lines, when nothing is in flight
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			slot <= '0;
		else if (word_taken)
			slot <= slot + 1'b1;
		else if (!col_issue && issue_dly == '0)
			slot <= '0;
	end

	// word 0 goes to the top slot
	always_ff @(posedge clk)
	begin
		if (word_taken)
			line[`DMA_WT_LINE_W - 1 - slot * `DMA_WORD_W -: `DMA_WORD_W] <= dram_q;
	end

endmodule

// File: pingpong_buf_writer.sv
`timescale 1ns/100ps
`include "dma_cfg.svh"

module pingpong_buf_writer
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      job_start,
	input  logic                      line_write,
	input  dma_pkg::buf_kind_t        target,
	input  logic                      bank_sel,
	input  logic [`DMA_BUF_A_W-1:0]   buf_addr_start,
	input  logic [`DMA_WT_LINE_W-1:0] line,
	output logic [1:0]                in_buf_cen,
	output logic [1:0]                in_buf_wen,
	output logic [`DMA_BUF_A_W-1:0]   in_buf_a,
	output logic [`DMA_IN_LINE_W-1:0] in_buf_di,
	output logic [1:0]                wt_buf_cen,
	output logic [1:0]                wt_buf_wen,
	output logic [`DMA_BUF_A_W-1:0]   wt_buf_a,
	output logic [`DMA_WT_LINE_W-1:0] wt_buf_di
);
	import dma_pkg::*;

	logic [`DMA_BUF_A_W-1:0] addr_cnt;
	logic in_sel;
	logic wt_sel;
	logic [1:0] bank_hot;

	assign in_sel = line_write && (target == BUF_INPUT);
	assign wt_sel = line_write && (target == BUF_WEIGHT);
	assign bank_hot = bank_sel ? 2'b10 : 2'b01;

	// one entry per line, starting at the job's base
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			addr_cnt <= '0;
		else if (job_start)
			addr_cnt <= buf_addr_start;
		else if (line_write)
			addr_cnt <= addr_cnt + 1'b1;
	end

	// input lines use only the first four words
	always_ff @(posedge clk)
	begin
		if (in_sel)
		begin
			in_buf_a <= addr_cnt;
			in_buf_di <= line[`DMA_WT_LINE_W-1 -: `DMA_IN_LINE_W];
		end
		if (wt_sel)
		begin
			wt_buf_a <= addr_cnt;
			wt_buf_di <= line;
		end
	end

	// active low, one bank of one kind for a single cycle
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			in_buf_cen <= 2'b11;
			in_buf_wen <= 2'b11;
		end
		else if (in_sel)
		begin
			in_buf_cen <= ~bank_hot;
			in_buf_wen <= ~bank_hot;
		end
		else
		begin
			in_buf_cen <= 2'b11;
			in_buf_wen <= 2'b11;
		end
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			wt_buf_cen <= 2'b11;
			wt_buf_wen <= 2'b11;
		end
		else if (wt_sel)
		begin
			wt_buf_cen <= ~bank_hot;
			wt_buf_wen <= ~bank_hot;
		end
		else
		begin
			wt_buf_cen <= 2'b11;
			wt_buf_wen <= 2'b11;
		end
	end

endmodule

// File: dma_read_top.sv
`timescale 1ns/100ps
`include "dma_cfg.svh"

module dma_read_top
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	input  dma_pkg::buf_kind_t        target,
	input  logic                      bank_sel,
	input  logic [`DMA_ADDR_W-1:0]    dram_addr_start,
	input  logic [`DMA_ADDR_W-1:0]    dram_addr_end,
	input  logic [`DMA_BUF_A_W-1:0]   buf_addr_start,
	output logic                      done,
	output logic                      busy,
	input  logic [`DMA_WORD_W-1:0]    dram_q,
	output logic                      dram_ras_n,
	output logic                      dram_cas_n,
	output logic [`DMA_DRAM_A_W-1:0]  dram_a,
	output logic [1:0]                in_buf_cen,
	output logic [1:0]                in_buf_wen,
	output logic [`DMA_BUF_A_W-1:0]   in_buf_a,
	output logic [`DMA_IN_LINE_W-1:0] in_buf_di,
	output logic [1:0]                wt_buf_cen,
	output logic [1:0]                wt_buf_wen,
	output logic [`DMA_BUF_A_W-1:0]   wt_buf_a,
	output logic [`DMA_WT_LINE_W-1:0] wt_buf_di
);

	logic col_issue;
	logic word_taken;
	logic job_start;
	logic line_write;
	logic [`DMA_WT_LINE_W-1:0] line;

	dram_burst_ctrl i_ctrl
	(
		.clk             (clk),
		.rst             (rst),
		.start           (start),
		.target          (target),
		.dram_addr_start (dram_addr_start),
		.dram_addr_end   (dram_addr_end),
		.word_taken      (word_taken),
		.dram_ras_n      (dram_ras_n),
		.dram_cas_n      (dram_cas_n),
		.dram_a          (dram_a),
		.col_issue       (col_issue),
		.job_start       (job_start),
		.line_write      (line_write),
		.last_line       (),
		.done            (done),
		.busy            (busy)
	);

	word_gather i_gather
	(
		.clk        (clk),
		.rst        (rst),
		.col_issue  (col_issue),
		.dram_q     (dram_q),
		.word_taken (word_taken),
		.line       (line)
	);

	pingpong_buf_writer i_writer
	(
		.clk            (clk),
		.rst            (rst),
		.job_start      (job_start),
		.line_write     (line_write),
		.target         (target),
		.bank_sel       (bank_sel),
		.buf_addr_start (buf_addr_start),
		.line           (line),
		.in_buf_cen     (in_buf_cen),
		.in_buf_wen     (in_buf_wen),
		.in_buf_a       (in_buf_a),
		.in_buf_di      (in_buf_di),
		.wt_buf_cen     (wt_buf_cen),
		.wt_buf_wen     (wt_buf_wen),
		.wt_buf_a       (wt_buf_a),
		.wt_buf_di      (wt_buf_di)
	);

endmodule

// File: tb_dram_model.sv
`timescale 1ns/100ps
`include "dma_cfg.svh"

module tb_dram_model
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     dram_ras_n,
	input  logic                     dram_cas_n,
	input  logic [`DMA_DRAM_A_W-1:0] dram_a,
	output logic [`DMA_WORD_W-1:0]   dram_q
);

	localparam int DEPTH = 4096;
	localparam int COL_W = `DMA_COL_MSB - `DMA_COL_LSB + 1;

	// word table, filled by the testbench, indexed by byte address bits 13:2
	logic [`DMA_WORD_W-1:0] mem [DEPTH];
	logic [`DMA_DRAM_A_W-1:0] open_row;
	logic [`DMA_ADDR_W-1:0] byte_addr;
	logic [`DMA_WORD_W-1:0] q_pipe [`DMA_CAS_LAT];
	logic [`DMA_CAS_LAT-1:0] v_pipe;

	always_comb
	begin
		byte_addr = '0;
		byte_addr[`DMA_ROW_MSB:`DMA_ROW_LSB] = open_row;
		byte_addr[`DMA_COL_MSB:`DMA_COL_LSB] = dram_a[COL_W-1:0];
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			open_row <= '0;
			v_pipe <= '0;
		end
		else
		begin
			if (!dram_ras_n && dram_cas_n)
				open_row <= dram_a;
			// one stage per cycle of cas latency
			v_pipe[0] <= !dram_ras_n && !dram_cas_n;
			q_pipe[0] <= mem[byte_addr[13:2]];
			for (int i = 1; i < `DMA_CAS_LAT; i++)
			begin
				v_pipe[i] <= v_pipe[i-1];
				q_pipe[i] <= q_pipe[i-1];
			end
		end
	end

	// read data only in its one valid cycle
	assign dram_q = v_pipe[`DMA_CAS_LAT-1] ? q_pipe[`DMA_CAS_LAT-1] : 'x;

endmodule

// File: dma_read_checker.sv
`timescale 1ns/100ps

module dma_read_checker
(
	input logic       clk,
	input logic       rst,
	input logic [1:0] in_buf_cen,
	input logic [1:0] in_buf_wen,
	input logic [1:0] wt_buf_cen,
	input logic [1:0] wt_buf_wen,
	input logic       dram_ras_n,
	input logic       dram_cas_n,
	input logic       done
);

	int fail_cnt = 0;

	a_in_agree: assert property (@(posedge clk) disable iff (rst) in_buf_cen == in_buf_wen)
		else begin $error("input buffer cen and wen differ"); fail_cnt++; end

	a_wt_agree: assert property (@(posedge clk) disable iff (rst) wt_buf_cen == wt_buf_wen)
		else begin $error("weight buffer cen and wen differ"); fail_cnt++; end

	// four bank enables, at most one low
	a_one_bank: assert property (@(posedge clk) disable iff (rst)
		$countones({in_buf_cen, wt_buf_cen}) >= 3)
		else begin $error("more than one buffer bank enabled"); fail_cnt++; end

	a_cas_ras: assert property (@(posedge clk) disable iff (rst) !dram_cas_n |-> !dram_ras_n)
		else begin $error("cas_n low without ras_n low"); fail_cnt++; end

	a_done_write: assert property (@(posedge clk) disable iff (rst)
		done |-> ((~in_buf_cen & ~in_buf_wen) != 2'b00 || (~wt_buf_cen & ~wt_buf_wen) != 2'b00))
		else begin $error("done without a buffer write"); fail_cnt++; end

endmodule

// File: tb_dma_read.sv
`timescale 1ns/100ps
`include "dma_cfg.svh"

module tb_dma_read;
	import dma_pkg::*;

	localparam int LINE_W = `DMA_WT_LINE_W;
	localparam int IN_PAD = `DMA_WT_LINE_W - `DMA_IN_LINE_W;
	// 15 lines over all tests
	localparam int TIMEOUT_CYCLES = 15 * 20 + 200;

	logic clk;
	logic rst;
	logic start;
	buf_kind_t target;
	logic bank_sel;
	logic [`DMA_ADDR_W-1:0] dram_addr_start;
	logic [`DMA_ADDR_W-1:0] dram_addr_end;
	logic [`DMA_BUF_A_W-1:0] buf_addr_start;
	logic done;
	logic busy;
	logic [`DMA_WORD_W-1:0] dram_q;
	logic dram_ras_n;
	logic dram_cas_n;
	logic [`DMA_DRAM_A_W-1:0] dram_a;
	logic [1:0] in_buf_cen;
	logic [1:0] in_buf_wen;
	logic [`DMA_BUF_A_W-1:0] in_buf_a;
	logic [`DMA_IN_LINE_W-1:0] in_buf_di;
	logic [1:0] wt_buf_cen;
	logic [1:0] wt_buf_wen;
	logic [`DMA_BUF_A_W-1:0] wt_buf_a;
	logic [`DMA_WT_LINE_W-1:0] wt_buf_di;

	logic [31:0] lfsr;
	logic [`DMA_WORD_W-1:0] ref_words [4096];
	int errors;
	int checks;
	int tests_run;
	int cycle_cnt;

	dma_read_top i_dut (.*);

	tb_dram_model i_dram
	(
		.clk        (clk),
		.rst        (rst),
		.dram_ras_n (dram_ras_n),
		.dram_cas_n (dram_cas_n),
		.dram_a     (dram_a),
		.dram_q     (dram_q)
	);

	bind dma_read_top dma_read_checker i_checker
	(
		.clk        (clk),
		.rst        (rst),
		.in_buf_cen (in_buf_cen),
		.in_buf_wen (in_buf_wen),
		.wt_buf_cen (wt_buf_cen),
		.wt_buf_wen (wt_buf_wen),
		.dram_ras_n (dram_ras_n),
		.dram_cas_n (dram_cas_n),
		.done       (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: no end of run after %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_word();
		logic [31:0] w;
		w = '0;
		for (int b = 0; b < 32; b++)
		begin
			lfsr = lfsr_next(lfsr);
			w = {w[30:0], lfsr[0]};
		end
		return w;
	endfunction

	task automatic fill_table();
		logic [31:0] w;
		for (int k = 0; k < 4096; k++)
		begin
			w = rand_word();
			ref_words[k] = w;
			i_dram.mem[k] = w;
		end
	endtask

	// first word in the top bits, unused low bits zero
	function automatic logic [LINE_W-1:0] expected_line(input logic [31:0] addr, input int words);
		logic [LINE_W-1:0] l;
		logic [31:0] a;
		l = '0;
		for (int i = 0; i < words; i++)
		begin
			a = addr + `DMA_WORD_BYTES * i;
			l[LINE_W - 1 - 32 * i -: 32] = ref_words[a[13:2]];
		end
		return l;
	endfunction

	task automatic check_value(input string name, input logic [LINE_W-1:0] got,
		input logic [LINE_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic run_job(input buf_kind_t kind, input logic bank, input logic [31:0] addr_first,
		input int lines, input logic [`DMA_BUF_A_W-1:0] buf_first, input bit poke);
		int words;
		int cyc;
		int done_cyc;
		bit finished;
		logic [31:0] addr_last;
		logic [31:0] a;
		logic [1:0] low_in;
		logic [1:0] low_wt;
		logic [1:0] own_low;
		logic [1:0] other_low;
		logic [`DMA_BUF_A_W-1:0] got_a [$];
		logic [LINE_W-1:0] got_d [$];
		logic [`DMA_DRAM_A_W-1:0] got_row [$];
		logic [`DMA_DRAM_A_W-1:0] got_col [$];
		words = (kind == BUF_WEIGHT) ? `DMA_WT_WORDS : `DMA_IN_WORDS;
		addr_last = addr_first + `DMA_WORD_BYTES * (lines * words - 1);
		cyc = 0;
		done_cyc = 0;
		finished = 0;
		@(posedge clk);
		start <= 1'b1;
		target <= kind;
		bank_sel <= bank;
		dram_addr_start <= addr_first;
		dram_addr_end <= addr_last;
		buf_addr_start <= buf_first;
		while (!finished)
		begin
			@(posedge clk);
			start <= poke && (cyc == 5);
			@(negedge clk);
			cyc++;
			if (!busy)
			begin
				$display("busy is low in cycle %0d of a running job", cyc);
				errors++;
			end
			if (!dram_ras_n && dram_cas_n)
				got_row.push_back(dram_a);
			if (!dram_ras_n && !dram_cas_n)
				got_col.push_back(dram_a);
			low_in = ~in_buf_cen | ~in_buf_wen;
			low_wt = ~wt_buf_cen | ~wt_buf_wen;
			own_low = (kind == BUF_INPUT) ? low_in : low_wt;
			other_low = (kind == BUF_INPUT) ? low_wt : low_in;
			if (other_low != 2'b00 || own_low[!bank])
			begin
				$display("an enable of a buffer bank outside the job fell in cycle %0d", cyc);
				errors++;
			end
			if (own_low[bank])
			begin
				got_a.push_back((kind == BUF_INPUT) ? in_buf_a : wt_buf_a);
				got_d.push_back((kind == BUF_INPUT) ? {in_buf_di, IN_PAD'(0)} : wt_buf_di);
			end
			if (done)
			begin
				finished = 1;
				done_cyc = cyc;
			end
		end

		check_value("done cycle", done_cyc, 1 + lines * (words + `DMA_CAS_LAT + 3));
		check_value("write count", got_a.size(), lines);
		check_value("row count", got_row.size(), lines);
		check_value("column count", got_col.size(), lines * words);
		for (int k = 0; k < lines; k++)
		begin
			a = addr_first + `DMA_WORD_BYTES * words * k;
			if (k < got_a.size())
			begin
				check_value((kind == BUF_INPUT) ? "in_buf_a" : "wt_buf_a", got_a[k], buf_first + k);
				check_value((kind == BUF_INPUT) ? "in_buf_di" : "wt_buf_di", got_d[k],
					expected_line(a, words));
			end
			if (k < got_row.size())
				check_value("dram_a row", got_row[k], a[`DMA_ROW_MSB:`DMA_ROW_LSB]);
		end
		for (int i = 0; i < got_col.size(); i++)
		begin
			a = addr_first + `DMA_WORD_BYTES * i;
			check_value("dram_a column", got_col[i], {2'b00, a[`DMA_COL_MSB:`DMA_COL_LSB]});
		end

		// engine must be quiet once done has pulsed
		repeat (2)
		begin
			@(negedge clk);
			if (done || busy || !dram_ras_n)
			begin
				$display("engine still active after done");
				errors++;
			end
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		$display("test %s: %s", name, (errors == errors_before) ? "ok" : "mismatches");
	endtask

	task automatic test_input_bank0();
		int e;
		e = errors;
		run_job(BUF_INPUT, 1'b0, 32'h0000_0100, 1, 7'h05, 0);
		report_test("input line into bank 0", e);
	endtask

	task automatic test_weight_bank1();
		int e;
		e = errors;
		run_job(BUF_WEIGHT, 1'b1, 32'h0000_0400, 3, 7'h10, 0);
		report_test("weight job into bank 1", e);
	endtask

	task automatic test_pingpong();
		int e;
		e = errors;
		run_job(BUF_INPUT, 1'b0, 32'h0000_0800, 2, 7'h20, 0);
		run_job(BUF_INPUT, 1'b1, 32'h0000_0a00, 2, 7'h40, 0);
		report_test("ping-pong", e);
	endtask

	task automatic test_row_change();
		int e;
		e = errors;
		// two lines in row 1, two in row 2
		run_job(BUF_INPUT, 1'b0, 32'h0000_1fe0, 4, 7'h30, 0);
		report_test("row change", e);
	endtask

	task automatic test_start_busy();
		int e;
		e = errors;
		run_job(BUF_WEIGHT, 1'b0, 32'h0000_0c00, 2, 7'h50, 1);
		run_job(BUF_INPUT, 1'b1, 32'h0000_0c80, 1, 7'h60, 0);
		report_test("start while busy", e);
	endtask

	initial
	begin
		rst = 1'b1;
		start = 1'b0;
		target = BUF_INPUT;
		bank_sel = 1'b0;
		dram_addr_start = '0;
		dram_addr_end = '0;
		buf_addr_start = '0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		lfsr = 32'ha1a3;
		fill_table();
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		test_input_bank0();
		test_weight_bank1();
		test_pingpong();
		test_row_change();
		test_start_busy();

		errors += i_dut.i_checker.fail_cnt;
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: list.f
+incdir+.
dma_pkg.sv
dram_burst_ctrl.sv
word_gather.sv
pingpong_buf_writer.sv
dma_read_top.sv
tb_dram_model.sv
dma_read_checker.sv
tb_dma_read.sv
